// ==== classifier_tests.txt ====
// 1 class feat data: weight write | 2 class data: bias write | 0: end of records
// 3 restart f0..f5 class0..2 logit0..2: run and check, restart is cycles to a 2nd start
1 5 0 4000
1 2 1 0100
1 7 2 FC00
2 2 1000
// one dominant class, then a spread of three
3 0 0100 0200 FF00 0000 0000 0000 5 7 2 00000040 00000004 00000002
3 0 0018 4000 FF80 0000 0000 0000 2 5 7 00000040 00000006 00000002
1 1 3 0100
1 3 3 0100
1 6 3 0100
// equal scores, then the same run with a second start mid-run
3 0 0000 0000 0000 0300 0000 0000 1 3 6 00000003 00000003 00000003
3 14 0000 0000 0000 0300 0000 0000 1 3 6 00000003 00000003 00000003
1 0 5 FFFF
1 4 4 0002
3 0 FFFF FF00 0001 FFFF FFF0 0005 0 0 0 00000000 00000000 00000000
// reload, same features
1 4 1 8000
1 6 1 FC00
1 7 1 FE00
2 7 7FFF
3 0 FFFF FF00 0001 FFFF FFF0 0005 4 6 7 0000007F 00000003 00000002
0

// ==== filelist.f ====
+incdir+.
cls_types_pkg.sv
cls_ctrl_pkg.sv
param_store.sv
fc_mac.sv
top3_ranker.sv
classifier_ctrl.sv
classifier_top.sv
tb_checker.sv
tb_classifier.sv

// ==== tb_classifier.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module tb_classifier
    import cls_types_pkg::*;
    import cls_ctrl_pkg::*;
();

    localparam int MEM_DEPTH   = 256;
    localparam int RUN_TIMEOUT = 1000;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_start;
    feature_t    i_features [0:`N_FEAT-1];
    logic        i_wr_en;
    wr_target_t  i_wr_target;
    class_idx_t  i_wr_class;
    feat_idx_t   i_wr_feat;
    weight_t     i_wr_data;
    class_idx_t  o_top_class [0:`N_TOP-1];
    acc_t        o_top_logit [0:`N_TOP-1];
    logic        o_finished;
    class_idx_t  exp_class [0:`N_TOP-1];
    acc_t        exp_logit [0:`N_TOP-1];
    logic [31:0] tests_mem [0:MEM_DEPTH-1];
    int          test_no;
    int          run_count;
    int          errors;
    int          passed;
    int          finishes;
    bit          fault;

    always #20 i_clk = ~i_clk;

    classifier_top DUT (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_features  (i_features),
        .i_wr_en     (i_wr_en),
        .i_wr_target (i_wr_target),
        .i_wr_class  (i_wr_class),
        .i_wr_feat   (i_wr_feat),
        .i_wr_data   (i_wr_data),
        .o_top_class (o_top_class),
        .o_top_logit (o_top_logit),
        .o_finished  (o_finished)
    );

    tb_checker u_checker (
        .i_clk       (i_clk),
        .i_finished  (o_finished),
        .i_test_no   (test_no),
        .i_top_class (o_top_class),
        .i_top_logit (o_top_logit),
        .i_exp_class (exp_class),
        .i_exp_logit (exp_logit),
        .o_errors    (errors),
        .o_passed    (passed),
        .o_finishes  (finishes)
    );

    task automatic write_param(input wr_target_t target, input logic [31:0] cls,
                               input logic [31:0] feat, input logic [31:0] data);
        @(posedge i_clk);
        i_wr_en     <= 1'b1;
        i_wr_target <= target;
        i_wr_class  <= class_idx_t'(cls);
        i_wr_feat   <= feat_idx_t'(feat);
        i_wr_data   <= weight_t'(data);
        @(posedge i_clk);
        i_wr_en <= 1'b0;
    endtask

    // one scoring run with an optional second start while busy
    task automatic run_test(input int base);
        int delay;
        int waited;
        bit seen;
        delay = tests_mem[base + 1];
        @(posedge i_clk);
        for (int i = 0; i < `N_FEAT; i++) begin
            i_features[i] <= feature_t'(tests_mem[base + 2 + i]);
        end
        for (int i = 0; i < `N_TOP; i++) begin
            exp_class[i] <= class_idx_t'(tests_mem[base + 8 + i]);
            exp_logit[i] <= acc_t'(tests_mem[base + 11 + i]);
        end
        test_no <= test_no + 1;
        run_count++;
        i_start <= 1'b1;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < RUN_TIMEOUT) begin
            @(posedge i_clk);
            waited++;
            seen = o_finished;
            i_start <= (delay != 0 && waited == delay && !seen);
        end
        if (!seen) begin
            $display("test %0d got no finished pulse within %0d cycles",
                     test_no, RUN_TIMEOUT);
            fault = 1'b1;
        end
    endtask

    initial begin
        int ptr;
        bit stop;
        i_clk       = 1'b0;
        i_rst_n     = 1'b1;
        i_start     = 1'b0;
        i_wr_en     = 1'b0;
        i_wr_target = WEIGHT;
        i_wr_class  = '0;
        i_wr_feat   = '0;
        i_wr_data   = '0;
        test_no     = 0;
        run_count   = 0;
        fault       = 1'b0;
        for (int i = 0; i < `N_FEAT; i++) begin
            i_features[i] = '0;
        end
        $readmemh("classifier_tests.txt", tests_mem);
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b0;
        ptr  = 0;
        stop = 1'b0;
        while (!stop && !fault && ptr < MEM_DEPTH - 16) begin
            case (tests_mem[ptr])
                32'd0: stop = 1'b1;
                32'd1: begin
                    write_param(WEIGHT, tests_mem[ptr + 1], tests_mem[ptr + 2],
                                tests_mem[ptr + 3]);
                    ptr += 4;
                end
                32'd2: begin
                    write_param(BIAS, tests_mem[ptr + 1], 32'd0, tests_mem[ptr + 2]);
                    ptr += 3;
                end
                32'd3: begin
                    run_test(ptr);
                    ptr += 14;
                end
                default: begin
                    $display("unknown record code %0h at word %0d of the test file",
                             tests_mem[ptr], ptr);
                    fault = 1'b1;
                end
            endcase
        end
        // let the checker finish its last compare
        @(posedge i_clk);
        if (run_count == 0 || finishes != run_count) begin
            $display("expected one finished pulse per run, saw %0d for %0d runs",
                     finishes, run_count);
            fault = 1'b1;
        end
        $display("runs %0d, passed %0d, mismatches %0d", run_count, passed, errors);
        if (!fault && errors == 0 && passed == run_count) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module tb_checker
    import cls_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_finished,
    input  int         i_test_no,
    input  class_idx_t i_top_class [0:`N_TOP-1],
    input  acc_t       i_top_logit [0:`N_TOP-1],
    input  class_idx_t i_exp_class [0:`N_TOP-1],
    input  acc_t       i_exp_logit [0:`N_TOP-1],
    output int         o_errors,
    output int         o_passed,
    output int         o_finishes
);

    initial begin
        o_errors   = 0;
        o_passed   = 0;
        o_finishes = 0;
    end

    // ranking outputs hold after the finished pulse
    always @(posedge i_clk) begin : compare
        int bad;
        bad = 0;
        if (i_finished) begin
            for (int i = 0; i < `N_TOP; i++) begin
                if (i_top_class[i] !== i_exp_class[i]) begin
                    $display("[FAIL] time %0d ns o_top_class[%0d] got %0d expected %0d",
                             $time, i, i_top_class[i], i_exp_class[i]);
                    bad++;
                end
                if (i_top_logit[i] !== i_exp_logit[i]) begin
                    $display("[FAIL] time %0d ns o_top_logit[%0d] got %0d expected %0d",
                             $time, i, i_top_logit[i], i_exp_logit[i]);
                    bad++;
                end
            end
            o_finishes = o_finishes + 1;
            if (bad == 0) begin
                o_passed = o_passed + 1;
                $display("test %0d passed, classes %0d %0d %0d", i_test_no,
                         i_top_class[0], i_top_class[1], i_top_class[2]);
            end else begin
                o_errors = o_errors + bad;
                $display("test %0d failed with %0d mismatches", i_test_no, bad);
            end
        end
    end

endmodule

// ==== classifier_top.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module classifier_top
    import cls_types_pkg::*;
    import cls_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  feature_t   i_features  [0:`N_FEAT-1],
    input  logic       i_wr_en,
    input  wr_target_t i_wr_target,
    input  class_idx_t i_wr_class,
    input  feat_idx_t  i_wr_feat,
    input  weight_t    i_wr_data,
    output class_idx_t o_top_class [0:`N_TOP-1],
    output acc_t       o_top_logit [0:`N_TOP-1],
    output logic       o_finished
);

    class_idx_t cur_class;
    feat_idx_t  feat_idx;
    weight_t    weight;
    weight_t    bias;
    acc_t       score;
    logic       mac_start;
    logic       mac_done;
    logic       rank_clear;
    logic       rank_insert;
    logic       rank_done;

    param_store u_param_store (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_en     (i_wr_en),
        .i_wr_target (i_wr_target),
        .i_wr_class  (i_wr_class),
        .i_wr_feat   (i_wr_feat),
        .i_wr_data   (i_wr_data),
        .i_class     (cur_class),
        .i_feat      (feat_idx),
        .o_weight    (weight),
        .o_bias      (bias)
    );

    fc_mac u_fc_mac (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (mac_start),
        .i_features (i_features),
        .i_weight   (weight),
        .i_bias     (bias),
        .o_feat_idx (feat_idx),
        .o_score    (score),
        .o_done     (mac_done)
    );

    top3_ranker u_top3_ranker (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (rank_clear),
        .i_insert    (rank_insert),
        .i_class     (cur_class),
        .i_score     (score),
        .o_done      (rank_done),
        .o_top_class (o_top_class),
        .o_top_logit (o_top_logit)
    );

    classifier_ctrl u_classifier_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_mac_done    (mac_done),
        .i_rank_done   (rank_done),
        .o_class       (cur_class),
        .o_mac_start   (mac_start),
        .o_rank_clear  (rank_clear),
        .o_rank_insert (rank_insert),
        .o_finished    (o_finished)
    );

endmodule

// ==== classifier_ctrl.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module classifier_ctrl
    import cls_types_pkg::*;
    import cls_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_mac_done,
    input  logic       i_rank_done,
    output class_idx_t o_class,
    output logic       o_mac_start,
    output logic       o_rank_clear,
    output logic       o_rank_insert,
    output logic       o_finished
);

    localparam class_idx_t LAST_CLASS = class_idx_t'(`N_CLASS - 1);

    ctrl_state_t state_r, state_w;
    class_idx_t  class_r, class_w;
    logic        mac_start_r, mac_start_w;
    logic        rank_clear_r, rank_clear_w;
    logic        rank_insert_r, rank_insert_w;
    logic        finished_r, finished_w;

    always_comb begin
        state_w       = state_r;
        class_w       = class_r;
        mac_start_w   = 1'b0;
        rank_clear_w  = 1'b0;
        rank_insert_w = 1'b0;
        finished_w    = 1'b0;

        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w      = SCORE;
                    class_w      = '0;
                    mac_start_w  = 1'b1;
                    rank_clear_w = 1'b1;
                end
            end
            SCORE: begin
                if (i_mac_done) begin
                    state_w       = RANK;
                    rank_insert_w = 1'b1;
                end
            end
            RANK: begin
                if (i_rank_done) begin
                    if (class_r == LAST_CLASS) begin
                        state_w    = DONE;
                        finished_w = 1'b1;
                    end else begin
                        state_w     = SCORE;
                        class_w     = class_r + 1'b1;
                        mac_start_w = 1'b1;
                    end
                end
            end
            DONE: begin
                state_w = IDLE;
            end
            default: begin
                state_w = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r       <= IDLE;
            class_r       <= '0;
            mac_start_r   <= 1'b0;
            rank_clear_r  <= 1'b0;
            rank_insert_r <= 1'b0;
            finished_r    <= 1'b0;
        end else begin
            state_r       <= state_w;
            class_r       <= class_w;
            mac_start_r   <= mac_start_w;
            rank_clear_r  <= rank_clear_w;
            rank_insert_r <= rank_insert_w;
            finished_r    <= finished_w;
        end
    end

    assign o_class       = class_r;
    assign o_mac_start   = mac_start_r;
    assign o_rank_clear  = rank_clear_r;
    assign o_rank_insert = rank_insert_r;
    assign o_finished    = finished_r;

endmodule

// ==== top3_ranker.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module top3_ranker
    import cls_types_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  logic       i_insert,
    input  class_idx_t i_class,
    input  acc_t       i_score,
    output logic       o_done,
    output class_idx_t o_top_class [0:`N_TOP-1],
    output acc_t       o_top_logit [0:`N_TOP-1]
);

    localparam int STEP_W = $clog2(`N_TOP);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`N_TOP - 1);

    class_idx_t        slot_class [0:`N_TOP-1];
    acc_t              slot_score [0:`N_TOP-1];
    class_idx_t        cand_class;
    acc_t              cand_score;
    logic [STEP_W-1:0] step;
    logic              busy;
    logic              done;
    logic              beats;

    // strict compare keeps the earlier class in place on a tie
    assign beats = cand_score > slot_score[step];

    // moving candidate swaps with any slot it beats
    always_ff @(posedge i_clk) begin
        if (i_insert) begin
            cand_class <= i_class;
            cand_score <= i_score;
        end else if (busy && beats) begin
            cand_class <= slot_class[step];
            cand_score <= slot_score[step];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            slot_class <= '{default: '0};
            slot_score <= '{default: '0};
            step       <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (i_clear) begin
                slot_class <= '{default: '0};
                slot_score <= '{default: '0};
                busy       <= 1'b0;
            end else if (i_insert) begin
                step <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                if (beats) begin
                    slot_class[step] <= cand_class;
                    slot_score[step] <= cand_score;
                end
                // one slot per cycle from slot 0 down
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `N_TOP; i++) begin
            o_top_logit[i] = slot_score[i] >>> `LOGIT_SHIFT;
        end
    end

    assign o_top_class = slot_class;
    assign o_done      = done;

endmodule

// ==== fc_mac.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module fc_mac
    import cls_types_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_start,
    input  feature_t  i_features [0:`N_FEAT-1],
    input  weight_t   i_weight,
    input  weight_t   i_bias,
    output feat_idx_t o_feat_idx,
    output acc_t      o_score,
    output logic      o_done
);

    localparam feat_idx_t BIAS_STEP = feat_idx_t'(`N_FEAT);

    feat_idx_t cnt;
    logic      busy;
    logic      done;
    acc_t      acc;
    acc_t      product;

    // full width signed product of the current feature and its weight
    assign product = i_features[cnt] * i_weight;

    // step counter and done pulse
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            cnt  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (i_start) begin
                cnt  <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                if (cnt == BIAS_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // accumulator holds the score until the next start
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            acc <= '0;
        end else if (busy) begin
            if (cnt == BIAS_STEP) begin
                acc <= acc + acc_t'(i_bias);
            end else begin
                acc <= acc + product;
            end
        end
    end

    assign o_feat_idx = cnt;
    assign o_score    = acc;
    assign o_done     = done;

endmodule

// ==== param_store.sv ====
`timescale 1ns/1ps

`include "cls_defs.svh"

module param_store
    import cls_types_pkg::*;
    import cls_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_en,
    input  wr_target_t i_wr_target,
    input  class_idx_t i_wr_class,
    input  feat_idx_t  i_wr_feat,
    input  weight_t    i_wr_data,
    input  class_idx_t i_class,
    input  feat_idx_t  i_feat,
    output weight_t    o_weight,
    output weight_t    o_bias
);

    localparam feat_idx_t NUM_FEAT = feat_idx_t'(`N_FEAT);

    weight_t weights [0:`N_CLASS-1][0:`N_FEAT-1];
    weight_t biases  [0:`N_CLASS-1];

    // host writes one entry per cycle
    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            weights <= '{default: '0};
            biases  <= '{default: '0};
        end else if (i_wr_en) begin
            case (i_wr_target)
                WEIGHT: begin
                    if (i_wr_feat < NUM_FEAT) begin
                        weights[i_wr_class][i_wr_feat] <= i_wr_data;
                    end
                end
                BIAS: begin
                    biases[i_wr_class] <= i_wr_data;
                end
                default: begin
                end
            endcase
        end
    end

    // feature index past the end is the bias step of the MAC
    assign o_weight = (i_feat < NUM_FEAT) ? weights[i_class][i_feat] : '0;
    assign o_bias   = biases[i_class];

endmodule

// ==== cls_ctrl_pkg.sv ====
package cls_ctrl_pkg;

    // run sequencer states
    typedef enum logic [1:0] {
        IDLE,
        SCORE,
        RANK,
        DONE
    } ctrl_state_t;

    // host write destination
    typedef enum logic {
        WEIGHT,
        BIAS
    } wr_target_t;

endpackage

// ==== cls_types_pkg.sv ====
`include "cls_defs.svh"

package cls_types_pkg;

    // input feature word
    typedef logic signed [`DATA_W-1:0] feature_t;

    // weight or bias word
    typedef logic signed [`DATA_W-1:0] weight_t;

    // running and final class score
    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [`CLASS_IDX_W-1:0] class_idx_t;

    // one step past the last feature selects the bias
    typedef logic [`FEAT_IDX_W-1:0] feat_idx_t;

endpackage

// ==== cls_defs.svh ====
`ifndef CLS_DEFS_SVH
`define CLS_DEFS_SVH

// classifier sizes
`define N_FEAT  6
`define N_CLASS 8
`define N_TOP   3

// datapath widths
`define DATA_W  16
`define ACC_W   32

// index widths with one extra feature step for the bias
`define CLASS_IDX_W ($clog2(`N_CLASS))
`define FEAT_IDX_W  ($clog2(`N_FEAT + 1))

// score to reported logit
`define LOGIT_SHIFT 16

`endif
